/* gopigo_cmd_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Robot command definitions
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package gopigo_cmd_pkg;

  // setting index, one per robot setting
  typedef logic [2:0] cmd_idx_t;

  localparam cmd_idx_t CMD_PWM_LEFT   = 3'd0;
  localparam cmd_idx_t CMD_PWM_RGHT   = 3'd1;
  localparam cmd_idx_t CMD_DPS_LIMIT  = 3'd2;
  localparam cmd_idx_t CMD_EYE_LEFT   = 3'd3;
  localparam cmd_idx_t CMD_EYE_RGHT   = 3'd4;
  localparam cmd_idx_t CMD_BLINK_LEFT = 3'd5;
  localparam cmd_idx_t CMD_BLINK_RGHT = 3'd6;
  localparam int       CMD_COUNT      = 7;

  typedef logic signed [7:0] pwm_t; // two's complement motor power
  typedef logic [15:0]       dps_t; // degrees per second
  typedef logic [23:0]       rgb_t; // R[23:16] G[15:8] B[7:0]

  // message types understood by the robot firmware
  localparam logic [7:0] OP_SET_LED       = 8'h06;
  localparam logic [7:0] OP_SET_MOTOR_PWM = 8'h0A;
  localparam logic [7:0] OP_SET_DPS_LIMIT = 8'h0F;

  localparam logic [7:0] MOTOR_LEFT = 8'h01;
  localparam logic [7:0] MOTOR_RGHT = 8'h02;
  localparam logic [7:0] MOTOR_BOTH = 8'h03;

  localparam logic [7:0] LED_EYE_LEFT   = 8'h02;
  localparam logic [7:0] LED_EYE_RGHT   = 8'h01;
  localparam logic [7:0] LED_BLINK_LEFT = 8'h04;
  localparam logic [7:0] LED_BLINK_RGHT = 8'h08;

  localparam dps_t DPS_RESET = 16'd15; // slow start for bench tests

  // button stepping
  localparam logic [7:0] PWM_STEP = 8'd32;
  localparam logic [7:0] PWM_WRAP = 8'd192;
  localparam dps_t       DPS_STEP = 16'd16;
  localparam dps_t       DPS_WRAP = 16'd1000;
  localparam logic [7:0] RGB_STEP = 8'd32;
  localparam logic [7:0] RGB_WRAP = 8'd128;

endpackage

`default_nettype wire

/* spi_cfg_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI link configuration
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package spi_cfg_pkg;

  typedef logic [7:0] byte_t;

  // up to six bytes, first byte on the wire in [47:40]
  typedef logic [47:0] frame_t;

  // number of valid bytes in a frame
  typedef logic [2:0] frame_len_t;

  // clocks per half sclk period
  localparam int SCLK_DIV_DEF = 4;

  // robot address byte
  localparam byte_t SPI_ADDR_DEF = 8'h08;

endpackage

`default_nettype wire

/* btn_cmd_stepper.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Button setting stepper
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module btn_cmd_stepper (
  input  logic                  rst,          // clock
  input  logic                  clk,          // async reset, active high
  input  logic                  btn_i,
  output gopigo_cmd_pkg::pwm_t  pwm_left_o,
  output gopigo_cmd_pkg::pwm_t  pwm_rght_o,
  output gopigo_cmd_pkg::dps_t  dps_limit_o,
  output gopigo_cmd_pkg::rgb_t  eye_left_o,
  output gopigo_cmd_pkg::rgb_t  eye_rght_o,
  output gopigo_cmd_pkg::rgb_t  blink_left_o,
  output gopigo_cmd_pkg::rgb_t  blink_rght_o
);

  import gopigo_cmd_pkg::*;

  // channel positions inside rgb_t
  localparam int CH_B = 0;
  localparam int CH_G = 1;
  localparam int CH_R = 2;

  logic [1:0] sync_q;      // two-flop synchronizer
  logic       btn_prev_q;  // edge register
  logic       press;
  cmd_idx_t   idx_q;       // setting hit by the next press

  pwm_t pwm_left_q;
  pwm_t pwm_rght_q;
  dps_t dps_limit_q;
  rgb_t eye_left_q;
  rgb_t eye_rght_q;
  rgb_t blink_left_q;
  rgb_t blink_rght_q;

  function automatic pwm_t step_pwm(input pwm_t v);
    if (unsigned'(v) >= PWM_WRAP)
      return '0;
    else
      return v + PWM_STEP;
  endfunction

  function automatic dps_t step_dps(input dps_t v);
    if (v >= DPS_WRAP)
      return '0;
    else
      return v + DPS_STEP;
  endfunction

  // test_ch decides the wrap, step_mask picks the channels that move
  function automatic rgb_t step_rgb(input rgb_t c, input int test_ch, input logic [2:0] step_mask);
    rgb_t r;
    r = c;
    if (c[test_ch*8 +: 8] >= RGB_WRAP) begin
      r = '0;
    end else begin
      for (int ch = 0; ch < 3; ch++) begin
        if (step_mask[ch])
          r[ch*8 +: 8] = c[ch*8 +: 8] + RGB_STEP;
      end
    end
    return r;
  endfunction

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      sync_q     <= '0;
      btn_prev_q <= 1'b0;
    end else begin
      sync_q     <= {sync_q[0], btn_i};
      btn_prev_q <= sync_q[1];
    end
  end

  assign press = sync_q[1] & ~btn_prev_q;

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      idx_q        <= CMD_PWM_LEFT;
      pwm_left_q   <= '0;
      pwm_rght_q   <= '0;
      dps_limit_q  <= DPS_RESET;
      eye_left_q   <= '0;
      eye_rght_q   <= '0;
      blink_left_q <= '0;
      blink_rght_q <= '0;
    end else if (press) begin
      idx_q <= (idx_q == cmd_idx_t'(CMD_COUNT - 1)) ? CMD_PWM_LEFT : idx_q + 3'd1;
      case (idx_q)
        CMD_PWM_LEFT:   pwm_left_q   <= step_pwm(pwm_left_q);
        CMD_PWM_RGHT:   pwm_rght_q   <= step_pwm(pwm_rght_q);
        CMD_DPS_LIMIT:  dps_limit_q  <= step_dps(dps_limit_q);
        CMD_EYE_LEFT:   eye_left_q   <= step_rgb(eye_left_q, CH_B, 3'b001);
        CMD_EYE_RGHT:   eye_rght_q   <= step_rgb(eye_rght_q, CH_G, 3'b010);
        CMD_BLINK_LEFT: blink_left_q <= step_rgb(blink_left_q, CH_R, 3'b100);
        CMD_BLINK_RGHT: blink_rght_q <= step_rgb(blink_rght_q, CH_B, 3'b111); // white
        default: ;
      endcase
    end
  end

  assign pwm_left_o   = pwm_left_q;
  assign pwm_rght_o   = pwm_rght_q;
  assign dps_limit_o  = dps_limit_q;
  assign eye_left_o   = eye_left_q;
  assign eye_rght_o   = eye_rght_q;
  assign blink_left_o = blink_left_q;
  assign blink_rght_o = blink_rght_q;

endmodule

`default_nettype wire

/* cmd_scheduler.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Command frame scheduler
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module cmd_scheduler #(
  parameter spi_cfg_pkg::byte_t SPI_ADDR = spi_cfg_pkg::SPI_ADDR_DEF
) (
  input  logic                    rst,  // clock
  input  logic                    clk,  // async reset, active high
  input  gopigo_cmd_pkg::pwm_t    pwm_left_i,
  input  gopigo_cmd_pkg::pwm_t    pwm_rght_i,
  input  gopigo_cmd_pkg::dps_t    dps_limit_i,
  input  gopigo_cmd_pkg::rgb_t    eye_left_i,
  input  gopigo_cmd_pkg::rgb_t    eye_rght_i,
  input  gopigo_cmd_pkg::rgb_t    blink_left_i,
  input  gopigo_cmd_pkg::rgb_t    blink_rght_i,
  output spi_cfg_pkg::frame_t     frame_o,
  output spi_cfg_pkg::frame_len_t frame_len_o,
  output logic                    req_o,
  input  logic                    ack_i,
  output logic                    rpi_running_o
);

  import gopigo_cmd_pkg::*;
  import spi_cfg_pkg::*;

  typedef enum logic [1:0] {IDLE, REQ, WAIT_ACK_LOW} state_t;

  state_t               state_q;
  logic                 req_q;
  logic                 running_q;
  cmd_idx_t             idx_q;      // setting in flight
  logic [CMD_COUNT-1:0] sent_q;     // sent at least once since reset
  logic [CMD_COUNT-1:0] pending;
  logic                 any_pend;
  cmd_idx_t             sel_idx;
  logic                 load;
  logic                 done;
  frame_t               next_frame;
  frame_len_t           next_len;
  frame_t               frame_q;
  frame_len_t           len_q;

  // last value sent for each setting
  pwm_t shd_pwm_left_q;
  pwm_t shd_pwm_rght_q;
  dps_t shd_dps_limit_q;
  rgb_t shd_eye_left_q;
  rgb_t shd_eye_rght_q;
  rgb_t shd_blink_left_q;
  rgb_t shd_blink_rght_q;

  assign pending[CMD_PWM_LEFT]   = ~sent_q[CMD_PWM_LEFT]   | (pwm_left_i != shd_pwm_left_q);
  assign pending[CMD_PWM_RGHT]   = ~sent_q[CMD_PWM_RGHT]   | (pwm_rght_i != shd_pwm_rght_q);
  assign pending[CMD_DPS_LIMIT]  = ~sent_q[CMD_DPS_LIMIT]  | (dps_limit_i != shd_dps_limit_q);
  assign pending[CMD_EYE_LEFT]   = ~sent_q[CMD_EYE_LEFT]   | (eye_left_i != shd_eye_left_q);
  assign pending[CMD_EYE_RGHT]   = ~sent_q[CMD_EYE_RGHT]   | (eye_rght_i != shd_eye_rght_q);
  assign pending[CMD_BLINK_LEFT] = ~sent_q[CMD_BLINK_LEFT] | (blink_left_i != shd_blink_left_q);
  assign pending[CMD_BLINK_RGHT] = ~sent_q[CMD_BLINK_RGHT] | (blink_rght_i != shd_blink_rght_q);

  // lowest pending index wins
  always_comb begin
    any_pend = 1'b0;
    sel_idx  = CMD_PWM_LEFT;
    for (int i = CMD_COUNT - 1; i >= 0; i--) begin
      if (pending[i]) begin
        any_pend = 1'b1;
        sel_idx  = cmd_idx_t'(i);
      end
    end
  end

  always_comb begin
    next_len   = 3'd6;
    next_frame = {SPI_ADDR, OP_SET_LED, LED_BLINK_RGHT, blink_rght_i};
    case (sel_idx)
      CMD_PWM_LEFT: begin
        next_len   = 3'd4;
        next_frame = {SPI_ADDR, OP_SET_MOTOR_PWM, MOTOR_LEFT, pwm_left_i, 16'h0000};
      end
      CMD_PWM_RGHT: begin
        next_len   = 3'd4;
        next_frame = {SPI_ADDR, OP_SET_MOTOR_PWM, MOTOR_RGHT, pwm_rght_i, 16'h0000};
      end
      CMD_DPS_LIMIT: begin
        next_len   = 3'd5;
        next_frame = {SPI_ADDR, OP_SET_DPS_LIMIT, MOTOR_BOTH, dps_limit_i, 8'h00};
      end
      CMD_EYE_LEFT:   next_frame = {SPI_ADDR, OP_SET_LED, LED_EYE_LEFT, eye_left_i};
      CMD_EYE_RGHT:   next_frame = {SPI_ADDR, OP_SET_LED, LED_EYE_RGHT, eye_rght_i};
      CMD_BLINK_LEFT: next_frame = {SPI_ADDR, OP_SET_LED, LED_BLINK_LEFT, blink_left_i};
      default: ;
    endcase
  end

  assign load = (state_q == IDLE) && any_pend && !ack_i;
  assign done = (state_q == REQ) && ack_i;

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      state_q   <= IDLE;
      req_q     <= 1'b0;
      idx_q     <= CMD_PWM_LEFT;
      sent_q    <= '0;
      running_q <= 1'b0;
    end else begin
      running_q <= running_q | (&sent_q);
      case (state_q)
        IDLE: if (load) begin
          req_q   <= 1'b1;
          idx_q   <= sel_idx;
          state_q <= REQ;
        end
        REQ: if (done) begin
          req_q         <= 1'b0;
          sent_q[idx_q] <= 1'b1;
          state_q       <= WAIT_ACK_LOW;
        end
        WAIT_ACK_LOW: if (!ack_i) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // the shadow takes the payload bytes of the frame just acknowledged
  always_ff @(posedge rst) begin
    if (load) begin
      frame_q <= next_frame;
      len_q   <= next_len;
    end
    if (done) begin
      case (idx_q)
        CMD_PWM_LEFT:   shd_pwm_left_q   <= frame_q[23:16];
        CMD_PWM_RGHT:   shd_pwm_rght_q   <= frame_q[23:16];
        CMD_DPS_LIMIT:  shd_dps_limit_q  <= frame_q[23:8];
        CMD_EYE_LEFT:   shd_eye_left_q   <= frame_q[23:0];
        CMD_EYE_RGHT:   shd_eye_rght_q   <= frame_q[23:0];
        CMD_BLINK_LEFT: shd_blink_left_q <= frame_q[23:0];
        CMD_BLINK_RGHT: shd_blink_rght_q <= frame_q[23:0];
        default: ;
      endcase
    end
  end

  assign frame_o       = frame_q;
  assign frame_len_o   = len_q;
  assign req_o         = req_q;
  assign rpi_running_o = running_q;

endmodule

`default_nettype wire

/* spi_master.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI master, mode 0
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module spi_master #(
  parameter int SCLK_DIV = spi_cfg_pkg::SCLK_DIV_DEF
) (
  input  logic                    rst,  // clock
  input  logic                    clk,  // async reset, active high
  input  spi_cfg_pkg::frame_t     frame_i,
  input  spi_cfg_pkg::frame_len_t frame_len_i,
  input  logic                    req_i,
  output logic                    ack_o,
  output logic                    sclk_o,
  output logic                    mosi_o,
  output logic                    spi_ss_n_o
);

  import spi_cfg_pkg::*;

  localparam int DIV_W = $clog2(2 * SCLK_DIV);

  typedef logic [DIV_W-1:0] div_cnt_t;

  localparam div_cnt_t HALF_LAST = div_cnt_t'(SCLK_DIV - 1);     // half sclk period
  localparam div_cnt_t GAP_LAST  = div_cnt_t'(2 * SCLK_DIV - 1); // min deselect time

  typedef enum logic [2:0] {IDLE, SELECT, SHIFT, DESELECT, ACK} state_t;

  state_t     state_q;
  div_cnt_t   div_cnt_q;
  logic [2:0] bit_cnt_q;
  frame_len_t byte_cnt_q;
  frame_t     sreg_q;     // shift register, msb goes out first
  frame_len_t len_q;
  logic       last_byte;
  logic       ack_q;
  logic       sclk_q;
  logic       mosi_q;
  logic       ss_n_q;

  assign last_byte = (byte_cnt_q == frame_len_t'(len_q - 3'd1));

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      state_q    <= IDLE;
      div_cnt_q  <= '0;
      bit_cnt_q  <= '0;
      byte_cnt_q <= '0;
      ack_q      <= 1'b0;
      sclk_q     <= 1'b0;
      mosi_q     <= 1'b0;
      ss_n_q     <= 1'b1;
    end else begin
      case (state_q)
        IDLE: if (req_i && !ack_q) state_q <= SELECT;
        SELECT: begin
          ss_n_q     <= 1'b0;
          mosi_q     <= sreg_q[47]; // first bit ahead of the first rising edge
          div_cnt_q  <= '0;
          bit_cnt_q  <= '0;
          byte_cnt_q <= '0;
          state_q    <= SHIFT;
        end
        SHIFT: begin
          if (div_cnt_q == HALF_LAST) begin
            div_cnt_q <= '0;
            sclk_q    <= ~sclk_q;
            if (sclk_q) begin // falling edge, move to next bit
              bit_cnt_q <= bit_cnt_q + 3'd1;
              mosi_q    <= sreg_q[47];
              if (bit_cnt_q == 3'd7) begin
                byte_cnt_q <= byte_cnt_q + 3'd1;
                if (last_byte) begin
                  mosi_q  <= 1'b0;
                  state_q <= DESELECT;
                end
              end
            end
          end else begin
            div_cnt_q <= div_cnt_q + 1'b1;
          end
        end
        DESELECT: begin
          // hold select for half a period past the last falling edge
          if (div_cnt_q == HALF_LAST) begin
            div_cnt_q <= '0;
            ss_n_q    <= 1'b1;
            state_q   <= ACK;
          end else begin
            div_cnt_q <= div_cnt_q + 1'b1;
          end
        end
        ACK: begin
          ack_q <= 1'b1;
          if (div_cnt_q != GAP_LAST)
            div_cnt_q <= div_cnt_q + 1'b1;
          else if (!req_i) begin
            ack_q   <= 1'b0;
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // frame payload, loaded on request and shifted on each falling sclk
  always_ff @(posedge rst) begin
    if (state_q == IDLE && req_i && !ack_q) begin
      sreg_q <= frame_i;
      len_q  <= frame_len_i;
    end else if (state_q == SELECT) begin
      sreg_q <= {sreg_q[46:0], 1'b0};
    end else if (state_q == SHIFT && div_cnt_q == HALF_LAST && sclk_q) begin
      sreg_q <= {sreg_q[46:0], 1'b0};
    end
  end

  assign ack_o      = ack_q;
  assign sclk_o     = sclk_q;
  assign mosi_o     = mosi_q;
  assign spi_ss_n_o = ss_n_q;

endmodule

`default_nettype wire

/* gopigo_spi_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Button to SPI command top
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module gopigo_spi_top #(
  parameter int                 SCLK_DIV = spi_cfg_pkg::SCLK_DIV_DEF,
  parameter spi_cfg_pkg::byte_t SPI_ADDR = spi_cfg_pkg::SPI_ADDR_DEF
) (
  input  logic rst,           // clock
  input  logic clk,           // async reset, active high
  input  logic btn_i,
  output logic sclk_o,
  output logic mosi_o,
  output logic spi_ss_n_o,    // active low
  output logic rpi_running_o  // initial round done
);

  import gopigo_cmd_pkg::*;
  import spi_cfg_pkg::*;

  pwm_t       pwm_left;
  pwm_t       pwm_rght;
  dps_t       dps_limit;
  rgb_t       eye_left;
  rgb_t       eye_rght;
  rgb_t       blink_left;
  rgb_t       blink_rght;
  frame_t     frame;
  frame_len_t frame_len;
  logic       req;
  logic       ack;

  btn_cmd_stepper i_stepper (
    .rst          (rst),
    .clk          (clk),
    .btn_i        (btn_i),
    .pwm_left_o   (pwm_left),
    .pwm_rght_o   (pwm_rght),
    .dps_limit_o  (dps_limit),
    .eye_left_o   (eye_left),
    .eye_rght_o   (eye_rght),
    .blink_left_o (blink_left),
    .blink_rght_o (blink_rght)
  );

  cmd_scheduler #(
    .SPI_ADDR (SPI_ADDR)
  ) i_scheduler (
    .rst           (rst),
    .clk           (clk),
    .pwm_left_i    (pwm_left),
    .pwm_rght_i    (pwm_rght),
    .dps_limit_i   (dps_limit),
    .eye_left_i    (eye_left),
    .eye_rght_i    (eye_rght),
    .blink_left_i  (blink_left),
    .blink_rght_i  (blink_rght),
    .frame_o       (frame),
    .frame_len_o   (frame_len),
    .req_o         (req),
    .ack_i         (ack),
    .rpi_running_o (rpi_running_o)
  );

  spi_master #(
    .SCLK_DIV (SCLK_DIV)
  ) i_spi_master (
    .rst         (rst),
    .clk         (clk),
    .frame_i     (frame),
    .frame_len_i (frame_len),
    .req_i       (req),
    .ack_o       (ack),
    .sclk_o      (sclk_o),
    .mosi_o      (mosi_o),
    .spi_ss_n_o  (spi_ss_n_o)
  );

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS  = 20,
  parameter int RST_CYCLES = 4
) (
  output logic rst,  // clock
  output logic clk   // reset, active high
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    rst = 1'b0;
    clk = 1'b1;
    repeat (RST_CYCLES) @(posedge rst);
    @(negedge rst);
    clk = 1'b0; // released between active edges
  end

  always #(PERIOD_NS / 2) rst = ~rst;

endmodule

`default_nettype wire

/* gopigo_spi_chk.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI master protocol checks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module gopigo_spi_chk (
  input logic rst,     // clock
  input logic clk,     // async reset, active high
  input logic req_i,
  input logic ack_i,
  input logic sclk_i,
  input logic ss_n_i
);

  timeunit 1ns;
  timeprecision 100ps;

  int fail_cnt = 0; // read by the testbench at the end

  ack_needs_req: assert property (@(posedge rst) disable iff (clk) $rose(ack_i) |-> req_i)
    else begin
      $error("ack rose while req was low");
      fail_cnt++;
    end

  // four-phase handshake, req may only drop once ack is seen
  req_held: assert property (@(posedge rst) disable iff (clk) req_i && !ack_i |=> req_i)
    else begin
      $error("req dropped before ack");
      fail_cnt++;
    end

  sclk_idle_low: assert property (@(posedge rst) disable iff (clk) ss_n_i |-> !sclk_i)
    else begin
      $error("sclk high while slave select is high");
      fail_cnt++;
    end

  ss_low_shift: assert property (@(posedge rst) disable iff (clk) $changed(sclk_i) |-> !ss_n_i)
    else begin
      $error("sclk toggled with slave select high");
      fail_cnt++;
    end

endmodule

`default_nettype wire

/* tb_gopigo_spi.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Button to SPI testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_gopigo_spi;

  timeunit 1ns;
  timeprecision 100ps;

  import gopigo_cmd_pkg::*;
  import spi_cfg_pkg::*;

  localparam int    SCLK_DIV  = 2;
  localparam byte_t ADDR      = SPI_ADDR_DEF;
  localparam int    QUIET     = 40; // clocks of ss_n high that mean the line is idle
  localparam int    FRAME_CYC = 6 * 8 * 2 * SCLK_DIV + 8 * SCLK_DIV + 16; // longest frame
  localparam int    ROWS      = 7;

  // presses, wait for idle after each press, expected frames in the row
  int tbl_presses [ROWS] = '{7, 3, 14, 60, 10, 380, 7};
  bit tbl_wait    [ROWS] = '{1, 0, 0, 1, 0, 1, 0};
  int tbl_frames  [ROWS] = '{7, 3, 8, 60, 8, 380, 7};

  logic        rst;    // clock
  logic        clk;    // reset
  logic        btn;
  logic        sclk;
  logic        mosi;
  logic        ss_n;
  logic        running;
  int          errors      = 0;
  int          cycles      = 0;
  int          cycle_limit = 100000;
  int          press_idx   = 0;
  int          frames_seen = 0;
  int          cur_bits    = 0;
  logic [47:0] cur_frame   = '0;
  logic [31:0] rng;
  logic [23:0] model     [CMD_COUNT];  // reference settings
  logic [23:0] last_sent [CMD_COUNT];
  logic [26:0] hist      [$];          // {index, value} the model ever held
  logic [47:0] rx_frame  [$];          // bytes left aligned with the first byte on top
  int          rx_len    [$];

  tb_clk_gen #(.PERIOD_NS(20), .RST_CYCLES(4)) i_clk_gen (
    .rst (rst),
    .clk (clk)
  );

  gopigo_spi_top #(.SCLK_DIV(SCLK_DIV), .SPI_ADDR(ADDR)) i_dut (
    .rst           (rst),
    .clk           (clk),
    .btn_i         (btn),
    .sclk_o        (sclk),
    .mosi_o        (mosi),
    .spi_ss_n_o    (ss_n),
    .rpi_running_o (running)
  );

  bind spi_master gopigo_spi_chk i_chk (
    .rst    (rst),
    .clk    (clk),
    .req_i  (req_i),
    .ack_i  (ack_o),
    .sclk_i (sclk_o),
    .ss_n_i (spi_ss_n_o)
  );

  task automatic check_value(input string name, input logic [47:0] got, input logic [47:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL at %0d ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_error(input string what);
    errors++;
    $display("ERROR at %0d ns: %s", $time, what);
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // one button step of setting idx
  function automatic logic [23:0] step_value(input int idx, input logic [23:0] v);
    case (idx)
      0, 1: return (v[7:0] >= 8'd192) ? 24'd0 : {16'd0, v[7:0] + 8'd32};
      2:    return (v[15:0] >= 16'd1000) ? 24'd0 : {8'd0, v[15:0] + 16'd16};
      3:    return (v[7:0] >= 8'd128) ? 24'd0 : {v[23:8], v[7:0] + 8'd32};
      4:    return (v[15:8] >= 8'd128) ? 24'd0 : {v[23:16], v[15:8] + 8'd32, v[7:0]};
      5:    return (v[23:16] >= 8'd128) ? 24'd0 : {v[23:16] + 8'd32, v[15:0]};
      default: begin // white blink where blue decides the wrap
        if (v[7:0] >= 8'd128)
          return 24'd0;
        return {v[23:16] + 8'd32, v[15:8] + 8'd32, v[7:0] + 8'd32};
      end
    endcase
  endfunction

  function automatic int frame_len(input int idx);
    if (idx < 2)
      return 4;
    return (idx == 2) ? 5 : 6;
  endfunction

  function automatic logic [47:0] frame_bytes(input int idx, input logic [23:0] v);
    case (idx)
      0:       return {ADDR, OP_SET_MOTOR_PWM, MOTOR_LEFT, v[7:0], 16'h0000};
      1:       return {ADDR, OP_SET_MOTOR_PWM, MOTOR_RGHT, v[7:0], 16'h0000};
      2:       return {ADDR, OP_SET_DPS_LIMIT, MOTOR_BOTH, v[15:8], v[7:0], 8'h00};
      3:       return {ADDR, OP_SET_LED, LED_EYE_LEFT, v};
      4:       return {ADDR, OP_SET_LED, LED_EYE_RGHT, v};
      5:       return {ADDR, OP_SET_LED, LED_BLINK_LEFT, v};
      default: return {ADDR, OP_SET_LED, LED_BLINK_RGHT, v};
    endcase
  endfunction

  // slave side in mode 0
  always @(posedge sclk) begin
    if (!ss_n) begin
      cur_frame = {cur_frame[46:0], mosi};
      cur_bits  = cur_bits + 1;
    end
  end

  always @(posedge ss_n) begin
    if (cur_bits > 0) begin
      if (cur_bits % 8 != 0 || cur_bits > 48)
        report_error($sformatf("frame of %0d bits is not a whole number of bytes", cur_bits));
      rx_frame.push_back(cur_frame << (48 - cur_bits));
      rx_len.push_back(cur_bits / 8);
      frames_seen++;
      if (frames_seen <= CMD_COUNT && running !== 1'b0)
        report_error("rpi_running_o went high before the initial round ended");
      cur_bits  = 0;
      cur_frame = '0;
    end
  end

  always @(posedge rst) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout after %0d cycles, the test did not finish", cycles);
      $display("Checks failed");
      $finish;
    end
  end

  // called and returns on a falling edge
  task automatic press_button();
    int hold;
    int gap;
    rng  = xorshift32(rng);
    hold = 2 + int'(rng % 3);
    rng  = xorshift32(rng);
    gap  = 2 + int'(rng % 3);
    btn  = 1'b1;
    repeat (hold) @(negedge rst);
    btn = 1'b0;
    repeat (gap) @(negedge rst);
    model[press_idx] = step_value(press_idx, model[press_idx]);
    hist.push_back({3'(press_idx), model[press_idx]});
    press_idx = (press_idx + 1) % CMD_COUNT;
  endtask

  task automatic wait_idle();
    int quiet;
    quiet = 0;
    while (quiet < QUIET) begin
      @(negedge rst);
      quiet = ss_n ? quiet + 1 : 0;
    end
  endtask

  // idx >= 0 expects idx, idx+1, ... in order, else any value from the history
  task automatic take_frames(input int idx);
    logic [47:0] got;
    int          got_len;
    int          hidx;
    int          cur;
    bit          found;
    cur = idx;
    while (rx_frame.size() > 0) begin
      got     = rx_frame.pop_front();
      got_len = rx_len.pop_front();
      if (cur >= 0) begin
        check_value($sformatf("length of frame %0d", cur), 48'(got_len), 48'(frame_len(cur)));
        check_value($sformatf("bytes of frame %0d", cur), got, frame_bytes(cur, model[cur]));
        if (got === frame_bytes(cur, model[cur]))
          last_sent[cur] = model[cur];
        cur = (cur + 1) % CMD_COUNT;
      end else begin
        found = 1'b0;
        foreach (hist[h]) begin
          hidx = int'(hist[h][26:24]);
          if (!found && got_len == frame_len(hidx) && got == frame_bytes(hidx, hist[h][23:0])) begin
            found = 1'b1;
            last_sent[hidx] = hist[h][23:0];
          end
        end
        if (!found)
          report_error($sformatf("frame %h of %0d bytes carries a value never stepped to",
                                 got, got_len));
      end
    end
  endtask

  initial begin
    int total;
    int first;
    int start;
    int assert_fails;
    btn   = 1'b0;
    rng   = 32'h630ebf4e;
    total = 0;
    foreach (tbl_presses[r])
      total += tbl_presses[r];
    cycle_limit = (total + 2 * CMD_COUNT) * (FRAME_CYC + 2 * QUIET);
    for (int i = 0; i < CMD_COUNT; i++) begin
      model[i] = (i == 2) ? 24'd15 : 24'd0; // dps limit starts at 15
      hist.push_back({3'(i), model[i]});
    end
    @(negedge clk);

    // every setting goes out once after reset
    wait_idle();
    check_value("initial frame count", 48'(frames_seen), 48'(CMD_COUNT));
    take_frames(0);
    check_value("rpi_running_o", 48'(running), 48'd1);

    for (int r = 0; r < ROWS; r++) begin
      start = frames_seen;
      for (int p = 0; p < tbl_presses[r]; p++) begin
        first = press_idx;
        press_button();
        if (tbl_wait[r]) begin
          wait_idle();
          check_value("frames per press", 48'(rx_frame.size()), 48'd1);
          take_frames(first);
        end
      end
      if (!tbl_wait[r]) begin
        wait_idle();
        take_frames(-1);
      end
      check_value($sformatf("frames in row %0d", r), 48'(frames_seen - start),
                  48'(tbl_frames[r]));
      for (int i = 0; i < CMD_COUNT; i++)
        check_value($sformatf("last value sent for setting %0d", i), 48'(last_sent[i]),
                    48'(model[i]));
    end

    assert_fails = i_dut.i_spi_master.i_chk.fail_cnt;
    $display("errors %0d, assertion failures %0d, frames %0d", errors, assert_fails,
             frames_seen);
    if (errors == 0 && assert_fails == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

/* gopigo_spi.f */
gopigo_cmd_pkg.sv
spi_cfg_pkg.sv
btn_cmd_stepper.sv
cmd_scheduler.sv
spi_master.sv
gopigo_spi_top.sv
tb_clk_gen.sv
gopigo_spi_chk.sv
tb_gopigo_spi.sv

/* Makefile */
# Verilator flow for the button to SPI command source
TOP = tb_gopigo_spi

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module gopigo_spi_top -f gopigo_spi.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f gopigo_spi.f
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee /dev/stderr | grep "All checks passed" > /dev/null

clean:
	rm -rf obj_dir
